/* rtc_setter.f */
common/rtc_setter_pkg.sv
common/rtc_write_if.sv
button_decode/button_decode.sv
verilog/field_sequencer.sv
verilog/write_queue.sv
verilog/rtc_setter_top.sv
verification/rtc_setter_checker.sv
verification/rtc_setter_tb.sv

/* Makefile */
# Verilator simulation of the RTC setter testbench

sim:
	verilator --binary --timing --timescale 1ns/1ps -j 0 --top-module rtc_setter_tb \
		-f rtc_setter.f -o rtc_setter_sim
	./obj_dir/rtc_setter_sim > sim.log
	cat sim.log
	! grep -q "TEST FAIL" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean

/* verification/rtc_setter_tb.sv */
`timescale 1ns/1ps

module rtc_setter_tb;

  localparam int NUM_ROWS       = 25;
  localparam int TIMEOUT_CYCLES = NUM_ROWS * (2 * rtc_setter_pkg::DEBOUNCE_CYCLES + 40);
  localparam int PRESS          = rtc_setter_pkg::DEBOUNCE_CYCLES + 4;
  localparam int SHORT          = rtc_setter_pkg::DEBOUNCE_CYCLES - 1;

  localparam int BTN_NONE  = 0;
  localparam int BTN_UP    = 1;
  localparam int BTN_DOWN  = 2;
  localparam int BTN_RIGHT = 3;
  localparam int BTN_LEFT  = 4;
  localparam int BTN_INIT  = 5;  // pulses init_i instead of a button

  localparam int READY_ON     = 0;
  localparam int READY_RANDOM = 1;
  localparam int READY_STALL  = 2;  // chip holds ready low, writes pile up

  logic       clk = 1'b0;
  logic       Reset;
  logic       init_i;
  logic       write_enable_i;
  logic       btn_up_i;
  logic       btn_down_i;
  logic       btn_left_i;
  logic       btn_right_i;
  logic [7:0] sec_i;
  logic [7:0] min_i;
  logic [7:0] hour_i;
  logic [7:0] day_i;
  logic [7:0] month_i;
  logic [7:0] year_i;
  logic [7:0] weekday_i;
  logic       rtc_ready_i = 1'b1;
  logic       rtc_valid_o;
  logic [7:0] rtc_addr_o;
  logic [7:0] rtc_data_o;
  logic       reset_hold_o;

  int         ready_mode = READY_ON;
  logic [7:0] chip_regs [256];
  int         cycles = 0;
  int         deferred_btn = BTN_NONE;

  string      row_name  [NUM_ROWS];
  int         row_btn   [NUM_ROWS];
  int         row_hold  [NUM_ROWS];
  logic       row_we    [NUM_ROWS];
  int         row_ready [NUM_ROWS];
  int         row_nwr   [NUM_ROWS];
  logic [7:0] row_addr  [NUM_ROWS];

  rtc_setter_top rtc_setter_top_i (
    .clk            (clk),
    .Reset          (Reset),
    .init_i         (init_i),
    .write_enable_i (write_enable_i),
    .btn_up_i       (btn_up_i),
    .btn_down_i     (btn_down_i),
    .btn_left_i     (btn_left_i),
    .btn_right_i    (btn_right_i),
    .sec_i          (sec_i),
    .min_i          (min_i),
    .hour_i         (hour_i),
    .day_i          (day_i),
    .month_i        (month_i),
    .year_i         (year_i),
    .weekday_i      (weekday_i),
    .rtc_ready_i    (rtc_ready_i),
    .rtc_valid_o    (rtc_valid_o),
    .rtc_addr_o     (rtc_addr_o),
    .rtc_data_o     (rtc_data_o),
    .reset_hold_o   (reset_hold_o)
  );

  rtc_setter_checker rtc_setter_checker_i (
    .clk          (clk),
    .Reset        (Reset),
    .rtc_valid_i  (rtc_valid_o),
    .rtc_ready_i  (rtc_ready_i),
    .rtc_addr_i   (rtc_addr_o),
    .rtc_data_i   (rtc_data_o),
    .reset_hold_i (reset_hold_o)
  );

  always #4 clk = ~clk;  // 8 ns period

  always @(negedge clk)
  begin
    case (ready_mode)
      READY_RANDOM: rtc_ready_i <= 1'($urandom);  // random stalls under back-pressure
      READY_STALL:  rtc_ready_i <= 1'b0;
      default:      rtc_ready_i <= 1'b1;
    endcase
  end

  always @(posedge clk)
  begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES)
    begin
      $display("timeout: the table did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("TEST FAIL");
      $finish;
    end
  end

  task automatic drive_time();
    sec_i     = chip_regs[8'h21];
    min_i     = chip_regs[8'h22];
    hour_i    = chip_regs[8'h23];
    day_i     = chip_regs[8'h24];
    month_i   = chip_regs[8'h25];
    year_i    = chip_regs[8'h26];
    weekday_i = chip_regs[8'h27];
  endtask

  // chip model, takes accepted writes and feeds the time inputs back
  initial
  begin
    for (int a = 0; a < 256; a++)
      chip_regs[a] = 8'(a) ^ 8'hDE;  // seconds starts at 0xFF
    drive_time();
    forever
    begin
      @(posedge clk);
      if (rtc_valid_o && rtc_ready_i)
        chip_regs[rtc_addr_o] = rtc_data_o;
      @(negedge clk);
      drive_time();
    end
  end

  task automatic add_row(input int idx, input string name, input int btn, input int hold,
                         input logic we, input int rdy, input int nwr, input logic [7:0] addr);
    row_name[idx]  = name;
    row_btn[idx]   = btn;
    row_hold[idx]  = hold;
    row_we[idx]    = we;
    row_ready[idx] = rdy;
    row_nwr[idx]   = nwr;
    row_addr[idx]  = addr;
  endtask

  task automatic fill_table();
    add_row(0,  "reset_init",        BTN_NONE,  0,     1'b1, READY_ON,     2, 8'h02);
    add_row(1,  "up_sec_wrap",       BTN_UP,    PRESS, 1'b1, READY_ON,     1, 8'h21);
    add_row(2,  "down_sec_wrap",     BTN_DOWN,  PRESS, 1'b1, READY_ON,     1, 8'h21);
    add_row(3,  "right_to_min",      BTN_RIGHT, PRESS, 1'b1, READY_ON,     0, 8'h00);
    add_row(4,  "right_to_hour",     BTN_RIGHT, PRESS, 1'b1, READY_ON,     0, 8'h00);
    add_row(5,  "right_to_day",      BTN_RIGHT, PRESS, 1'b1, READY_ON,     0, 8'h00);
    add_row(6,  "right_to_month",    BTN_RIGHT, PRESS, 1'b1, READY_ON,     0, 8'h00);
    add_row(7,  "right_to_year",     BTN_RIGHT, PRESS, 1'b1, READY_ON,     0, 8'h00);
    add_row(8,  "right_to_weekday",  BTN_RIGHT, PRESS, 1'b1, READY_ON,     0, 8'h00);
    add_row(9,  "up_weekday",        BTN_UP,    PRESS, 1'b1, READY_ON,     1, 8'h27);
    add_row(10, "right_wrap",        BTN_RIGHT, PRESS, 1'b1, READY_ON,     0, 8'h00);
    add_row(11, "up_sec_after_wrap", BTN_UP,    PRESS, 1'b1, READY_ON,     1, 8'h21);
    add_row(12, "left_wrap",         BTN_LEFT,  PRESS, 1'b1, READY_ON,     0, 8'h00);
    add_row(13, "up_weekday_left",   BTN_UP,    PRESS, 1'b1, READY_ON,     1, 8'h27);
    add_row(14, "right_to_sec",      BTN_RIGHT, PRESS, 1'b1, READY_ON,     0, 8'h00);
    add_row(15, "short_press",       BTN_UP,    SHORT, 1'b1, READY_ON,     0, 8'h00);
    add_row(16, "press_we_low",      BTN_UP,    PRESS, 1'b0, READY_ON,     0, 8'h00);
    add_row(17, "we_restore",        BTN_NONE,  0,     1'b1, READY_ON,     1, 8'h21);
    add_row(18, "burst_up_sec",      BTN_UP,    PRESS, 1'b1, READY_STALL,  1, 8'h21);
    add_row(19, "burst_right_min",   BTN_RIGHT, PRESS, 1'b1, READY_STALL,  0, 8'h00);
    add_row(20, "burst_down_min",    BTN_DOWN,  PRESS, 1'b1, READY_STALL,  1, 8'h22);
    add_row(21, "burst_right_hour",  BTN_RIGHT, PRESS, 1'b1, READY_STALL,  0, 8'h00);
    add_row(22, "burst_up_hour",     BTN_UP,    PRESS, 1'b1, READY_RANDOM, 1, 8'h23);
    add_row(23, "bp_init_pulse",     BTN_INIT,  0,     1'b1, READY_RANDOM, 2, 8'h02);
    add_row(24, "up_sec_after_init", BTN_UP,    PRESS, 1'b1, READY_ON,     1, 8'h21);
  endtask

  task automatic set_button(input int btn, input logic level);
    case (btn)
      BTN_UP:    btn_up_i = level;
      BTN_DOWN:  btn_down_i = level;
      BTN_RIGHT: btn_right_i = level;
      BTN_LEFT:  btn_left_i = level;
      default:   ;
    endcase
  endtask

  task automatic run_row(input int r);
    logic [7:0] value;
    int         op;
    logic       drain;
    rtc_setter_checker_i.start_test(row_name[r]);
    write_enable_i = row_we[r];
    ready_mode <= row_ready[r];
    drain = (row_ready[r] != READY_STALL);  // stalled writes stay queued for a later row
    op = (row_btn[r] == BTN_UP || row_btn[r] == BTN_DOWN) ? row_btn[r] : deferred_btn;
    if (row_nwr[r] == 2)
    begin
      rtc_setter_checker_i.expect_write(8'h02, 8'h10);
      rtc_setter_checker_i.expect_write(8'h02, 8'h00);
    end
    else if (row_nwr[r] == 1)
    begin
      value = chip_regs[row_addr[r]];
      value = (op == BTN_UP) ? value + 8'd1 : value - 8'd1;  // wraps mod 256
      rtc_setter_checker_i.expect_write(row_addr[r], value);
    end
    if (!row_we[r])
      deferred_btn = row_btn[r];  // command waits in the decoder until editing is enabled
    Reset = 1'b0;
    if (row_btn[r] == BTN_INIT)
    begin
      init_i = 1'b1;
      @(negedge clk);
      init_i = 1'b0;
    end
    set_button(row_btn[r], 1'b1);
    repeat (row_hold[r]) @(negedge clk);
    set_button(row_btn[r], 1'b0);
    repeat (rtc_setter_pkg::DEBOUNCE_CYCLES + 4) @(negedge clk);  // button rearms
    if (drain)
    begin
      while (rtc_setter_checker_i.pending_writes() != 0)
        @(negedge clk);
    end
    repeat (6) @(negedge clk);  // room for stray writes
    rtc_setter_checker_i.end_test(row_nwr[r] == 2, drain);
  endtask

  initial
  begin
    void'($urandom(37));
    Reset          = 1'b1;
    init_i         = 1'b0;
    write_enable_i = 1'b1;
    btn_up_i       = 1'b0;
    btn_down_i     = 1'b0;
    btn_left_i     = 1'b0;
    btn_right_i    = 1'b0;
    fill_table();
    repeat (10) @(negedge clk);
    for (int r = 0; r < NUM_ROWS; r++)
      run_row(r);
    rtc_setter_checker_i.report_counts();
    if (rtc_setter_checker_i.error_total() == 0)
      $display("TEST PASS");
    else
      $display("TEST FAIL");
    $finish;
  end

endmodule

/* verification/rtc_setter_checker.sv */
`timescale 1ns/1ps

module rtc_setter_checker (
  input logic       clk,
  input logic       Reset,
  input logic       rtc_valid_i,
  input logic       rtc_ready_i,
  input logic [7:0] rtc_addr_i,
  input logic [7:0] rtc_data_i,
  input logic       reset_hold_i
);

  logic [15:0] exp_q [$];  // {addr, data} in chip order
  string       test_name   = "reset";
  int          mon_errors  = 0;
  int          task_errors = 0;
  int          start_mark  = 0;
  int          pass_count  = 0;
  int          fail_count  = 0;
  logic        released    = 1'b0;  // release write has reached the chip
  logic        hold_q      = 1'b1;

  task automatic start_test(input string name);
    test_name  = name;
    start_mark = mon_errors + task_errors;
  endtask

  task automatic expect_write(input logic [7:0] addr, input logic [7:0] data);
    exp_q.push_back({addr, data});
  endtask

  function automatic int pending_writes();
    return exp_q.size();
  endfunction

  function automatic int error_total();
    return mon_errors + task_errors;
  endfunction

  task automatic end_test(input logic check_hold, input logic check_empty);
    int row_errs;
    if (check_empty && exp_q.size() != 0)
    begin
      $display("%s: %0d expected write(s) never reached the chip port", test_name, exp_q.size());
      task_errors++;
      exp_q.delete();
    end
    if (check_hold && reset_hold_i)
    begin
      $display("%s: reset_hold_o is still high after the release write", test_name);
      task_errors++;
    end
    row_errs = mon_errors + task_errors - start_mark;
    if (row_errs == 0)
    begin
      $display("PASS %s", test_name);
      pass_count++;
    end
    else
    begin
      $display("FAIL %s: %0d error(s)", test_name, row_errs);
      fail_count++;
    end
  endtask

  task automatic report_counts();
    $display("tests passed: %0d, tests failed: %0d, errors: %0d",
             pass_count, fail_count, error_total());
  endtask

  always @(posedge clk)
  begin : monitor
    logic [15:0] want;
    if (Reset)
    begin
      if (rtc_valid_i || !reset_hold_i)
      begin
        $display("%s: chip port or reset_hold_o not in reset state during Reset", test_name);
        mon_errors++;
      end
      released = 1'b0;
    end
    else
    begin
      if (!reset_hold_i && hold_q && !released)
      begin
        $display("%s: reset_hold_o fell before the release write reached the chip", test_name);
        mon_errors++;
      end
      if (rtc_valid_i && rtc_ready_i)
      begin
        if (exp_q.size() == 0)
        begin
          $display("%s: unexpected write of 0x%02h to register 0x%02h",
                   test_name, rtc_data_i, rtc_addr_i);
          mon_errors++;
        end
        else
        begin
          want = exp_q.pop_front();
          if (want != {rtc_addr_i, rtc_data_i})
          begin
            $display("FAIL %s: expected addr 0x%02h data 0x%02h, actual addr 0x%02h data 0x%02h",
                     test_name, want[15:8], want[7:0], rtc_addr_i, rtc_data_i);
            mon_errors++;
          end
        end
        if (rtc_addr_i == 8'h02)
        begin
          if (rtc_data_i == 8'h10 && !reset_hold_i)
          begin
            $display("%s: reset_hold_o is low while the hold write reaches the chip", test_name);
            mon_errors++;
          end
          released = (rtc_data_i == 8'h00);  // hold write clears it
        end
      end
    end
    hold_q = reset_hold_i;
  end

endmodule

/* verilog/rtc_setter_top.sv */
`timescale 1ns/1ps

module rtc_setter_top (
  input  logic       clk,
  input  logic       Reset,
  input  logic       init_i,
  input  logic       write_enable_i,
  input  logic       btn_up_i,
  input  logic       btn_down_i,
  input  logic       btn_left_i,
  input  logic       btn_right_i,
  input  logic [7:0] sec_i,
  input  logic [7:0] min_i,
  input  logic [7:0] hour_i,
  input  logic [7:0] day_i,
  input  logic [7:0] month_i,
  input  logic [7:0] year_i,
  input  logic [7:0] weekday_i,
  input  logic       rtc_ready_i,
  output logic       rtc_valid_o,
  output logic [7:0] rtc_addr_o,
  output logic [7:0] rtc_data_o,
  output logic       reset_hold_o
);

  rtc_setter_pkg::rtc_time_t time_s;
  rtc_setter_pkg::edit_op_e  cmd_op;
  logic                      cmd_valid;
  logic                      cmd_ready;
  logic                      release_done;

  rtc_write_if wr_if ();

  assign time_s = '{
    seconds: sec_i,
    minutes: min_i,
    hours:   hour_i,
    day:     day_i,
    month:   month_i,
    year:    year_i,
    weekday: weekday_i
  };

  button_decode button_decode_i (
    .clk         (clk),
    .Reset       (Reset),
    .btn_up_i    (btn_up_i),
    .btn_down_i  (btn_down_i),
    .btn_left_i  (btn_left_i),
    .btn_right_i (btn_right_i),
    .cmd_ready_i (cmd_ready),
    .cmd_valid_o (cmd_valid),
    .cmd_op_o    (cmd_op)
  );

  field_sequencer field_sequencer_i (
    .clk            (clk),
    .Reset          (Reset),
    .init_i         (init_i),
    .write_enable_i (write_enable_i),
    .time_i         (time_s),
    .cmd_valid_i    (cmd_valid),
    .cmd_op_i       (cmd_op),
    .cmd_ready_o    (cmd_ready),
    .wr             (wr_if.seq),
    .release_done_i (release_done),
    .reset_hold_o   (reset_hold_o)
  );

  write_queue write_queue_i (
    .clk            (clk),
    .Reset          (Reset),
    .wr             (wr_if.queue),
    .rtc_addr_o     (rtc_addr_o),
    .rtc_data_o     (rtc_data_o),
    .rtc_valid_o    (rtc_valid_o),
    .rtc_ready_i    (rtc_ready_i),
    .release_done_o (release_done)
  );

endmodule

/* verilog/write_queue.sv */
`timescale 1ns/1ps

module write_queue (
  input  logic                                  clk,
  input  logic                                  Reset,
  rtc_write_if.queue                            wr,
  output logic [rtc_setter_pkg::REG_ADDR_W-1:0] rtc_addr_o,
  output logic [rtc_setter_pkg::REG_DATA_W-1:0] rtc_data_o,
  output logic                                  rtc_valid_o,
  input  logic                                  rtc_ready_i,
  output logic                                  release_done_o
);

  logic [rtc_setter_pkg::REG_ADDR_W-1:0] addr_mem [rtc_setter_pkg::QUEUE_DEPTH];
  logic [rtc_setter_pkg::REG_DATA_W-1:0] data_mem [rtc_setter_pkg::QUEUE_DEPTH];
  logic [rtc_setter_pkg::QUEUE_DEPTH-1:0] rel_mem;
  logic [rtc_setter_pkg::QUEUE_PTR_W-1:0] wr_ptr;
  logic [rtc_setter_pkg::QUEUE_PTR_W-1:0] rd_ptr;
  logic [rtc_setter_pkg::QUEUE_CNT_W-1:0] count;
  logic                                   push;
  logic                                   pop;

  function automatic logic [rtc_setter_pkg::QUEUE_PTR_W-1:0] ptr_next(
    logic [rtc_setter_pkg::QUEUE_PTR_W-1:0] ptr
  );
    if (ptr == rtc_setter_pkg::QUEUE_PTR_W'(rtc_setter_pkg::QUEUE_DEPTH - 1))
      return '0;
    return ptr + 1'b1;
  endfunction

  assign wr.wr_ready = (count != rtc_setter_pkg::QUEUE_CNT_W'(rtc_setter_pkg::QUEUE_DEPTH));
  assign rtc_valid_o = (count != '0);
  assign push        = wr.wr_valid && wr.wr_ready;
  assign pop         = rtc_valid_o && rtc_ready_i;

  // oldest entry faces the chip
  assign rtc_addr_o     = addr_mem[rd_ptr];
  assign rtc_data_o     = data_mem[rd_ptr];
  assign release_done_o = pop && rel_mem[rd_ptr];

  always_ff @(posedge clk or posedge Reset)
  begin
    if (Reset)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (push)
        wr_ptr <= ptr_next(wr_ptr);
      if (pop)
        rd_ptr <= ptr_next(rd_ptr);
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // both or neither
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (push)
    begin
      addr_mem[wr_ptr] <= wr.wr_addr;
      data_mem[wr_ptr] <= wr.wr_data;
      rel_mem[wr_ptr]  <= wr.wr_release;
    end
  end

endmodule

/* verilog/field_sequencer.sv */
`timescale 1ns/1ps

module field_sequencer (
  input  logic                      clk,
  input  logic                      Reset,
  input  logic                      init_i,
  input  logic                      write_enable_i,
  input  rtc_setter_pkg::rtc_time_t time_i,
  input  logic                      cmd_valid_i,
  input  rtc_setter_pkg::edit_op_e  cmd_op_i,
  output logic                      cmd_ready_o,
  rtc_write_if.seq                  wr,
  input  logic                      release_done_i,
  output logic                      reset_hold_o
);

  rtc_setter_pkg::seq_state_e                state;
  logic                                      rel_sent;  // release write handed to the queue
  logic                                      field_st;
  logic                                      accept;
  logic                                      edit;
  logic                                      issue_hold;
  logic                                      issue_rel;
  logic [rtc_setter_pkg::REG_DATA_W-1:0]     cur_value;
  logic [rtc_setter_pkg::REG_ADDR_W-1:0]     field_addr;

  function automatic rtc_setter_pkg::seq_state_e next_field(rtc_setter_pkg::seq_state_e s);
    case (s)
      rtc_setter_pkg::ST_SECONDS: return rtc_setter_pkg::ST_MINUTES;
      rtc_setter_pkg::ST_MINUTES: return rtc_setter_pkg::ST_HOURS;
      rtc_setter_pkg::ST_HOURS:   return rtc_setter_pkg::ST_DAY;
      rtc_setter_pkg::ST_DAY:     return rtc_setter_pkg::ST_MONTH;
      rtc_setter_pkg::ST_MONTH:   return rtc_setter_pkg::ST_YEAR;
      rtc_setter_pkg::ST_YEAR:    return rtc_setter_pkg::ST_WEEKDAY;
      default:                    return rtc_setter_pkg::ST_SECONDS;  // weekday wraps
    endcase
  endfunction

  function automatic rtc_setter_pkg::seq_state_e prev_field(rtc_setter_pkg::seq_state_e s);
    case (s)
      rtc_setter_pkg::ST_MINUTES: return rtc_setter_pkg::ST_SECONDS;
      rtc_setter_pkg::ST_HOURS:   return rtc_setter_pkg::ST_MINUTES;
      rtc_setter_pkg::ST_DAY:     return rtc_setter_pkg::ST_HOURS;
      rtc_setter_pkg::ST_MONTH:   return rtc_setter_pkg::ST_DAY;
      rtc_setter_pkg::ST_YEAR:    return rtc_setter_pkg::ST_MONTH;
      rtc_setter_pkg::ST_WEEKDAY: return rtc_setter_pkg::ST_YEAR;
      default:                    return rtc_setter_pkg::ST_WEEKDAY;  // seconds wraps back
    endcase
  endfunction

  always_comb
  begin
    case (state)
      rtc_setter_pkg::ST_MINUTES: cur_value = time_i.minutes;
      rtc_setter_pkg::ST_HOURS:   cur_value = time_i.hours;
      rtc_setter_pkg::ST_DAY:     cur_value = time_i.day;
      rtc_setter_pkg::ST_MONTH:   cur_value = time_i.month;
      rtc_setter_pkg::ST_YEAR:    cur_value = time_i.year;
      rtc_setter_pkg::ST_WEEKDAY: cur_value = time_i.weekday;
      default:                    cur_value = time_i.seconds;
    endcase
  end

  // field registers sit at consecutive addresses from seconds
  assign field_addr = rtc_setter_pkg::FIELD_ADDR_BASE +
                      rtc_setter_pkg::REG_ADDR_W'(state) -
                      rtc_setter_pkg::REG_ADDR_W'(rtc_setter_pkg::ST_SECONDS);

  assign field_st    = (state != rtc_setter_pkg::ST_INIT_HOLD) &&
                       (state != rtc_setter_pkg::ST_INIT_RELEASE);
  assign cmd_ready_o = field_st && !wr.wr_valid && write_enable_i && !init_i;
  assign accept      = cmd_valid_i && cmd_ready_o;
  assign edit        = accept && ((cmd_op_i == rtc_setter_pkg::OP_INC) ||
                                  (cmd_op_i == rtc_setter_pkg::OP_DEC));
  assign issue_hold  = (state == rtc_setter_pkg::ST_INIT_HOLD) && !init_i && !wr.wr_valid;
  assign issue_rel   = (state == rtc_setter_pkg::ST_INIT_RELEASE) && !rel_sent && !wr.wr_valid;

  always_ff @(posedge clk or posedge Reset)
  begin
    if (Reset)
    begin
      state        <= rtc_setter_pkg::ST_INIT_HOLD;
      wr.wr_valid  <= 1'b0;
      rel_sent     <= 1'b0;
      reset_hold_o <= 1'b1;
    end
    else
    begin
      if (wr.wr_valid && wr.wr_ready)
        wr.wr_valid <= 1'b0;
      if (issue_hold || issue_rel || edit)
        wr.wr_valid <= 1'b1;  // only when nothing is pending, so no clash with the clear
      if (init_i)
      begin
        state        <= rtc_setter_pkg::ST_INIT_HOLD;
        rel_sent     <= 1'b0;
        reset_hold_o <= 1'b1;
      end
      else
      begin
        case (state)
          rtc_setter_pkg::ST_INIT_HOLD:
          begin
            if (issue_hold)
              state <= rtc_setter_pkg::ST_INIT_RELEASE;
          end
          rtc_setter_pkg::ST_INIT_RELEASE:
          begin
            if (issue_rel)
              rel_sent <= 1'b1;
            if (rel_sent && !wr.wr_valid && release_done_i)
            begin
              state        <= rtc_setter_pkg::ST_SECONDS;  // chip took the release
              rel_sent     <= 1'b0;
              reset_hold_o <= 1'b0;
            end
          end
          default:
          begin
            if (accept && cmd_op_i == rtc_setter_pkg::OP_NEXT)
              state <= next_field(state);
            else if (accept && cmd_op_i == rtc_setter_pkg::OP_PREV)
              state <= prev_field(state);
          end
        endcase
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (issue_hold)
    begin
      wr.wr_addr    <= rtc_setter_pkg::CTRL_ADDR;
      wr.wr_data    <= rtc_setter_pkg::CTRL_HOLD;
      wr.wr_release <= 1'b0;
    end
    else if (issue_rel)
    begin
      wr.wr_addr    <= rtc_setter_pkg::CTRL_ADDR;
      wr.wr_data    <= rtc_setter_pkg::CTRL_RELEASE;
      wr.wr_release <= 1'b1;
    end
    else if (edit)
    begin
      wr.wr_addr    <= field_addr;
      wr.wr_data    <= (cmd_op_i == rtc_setter_pkg::OP_INC) ? cur_value + 1'b1
                                                            : cur_value - 1'b1;  // wraps mod 256
      wr.wr_release <= 1'b0;
    end
  end

endmodule

/* button_decode/button_decode.sv */
`timescale 1ns/1ps

module button_decode (
  input  logic                     clk,
  input  logic                     Reset,
  input  logic                     btn_up_i,
  input  logic                     btn_down_i,
  input  logic                     btn_left_i,
  input  logic                     btn_right_i,
  input  logic                     cmd_ready_i,
  output logic                     cmd_valid_o,
  output rtc_setter_pkg::edit_op_e cmd_op_o
);

  localparam int NUM_BTN = 4;

  // index order is also the priority order: up, down, right, left
  logic [NUM_BTN-1:0]                                btn_raw;
  logic [NUM_BTN-1:0]                                level;  // debounced level
  logic [NUM_BTN-1:0][rtc_setter_pkg::DEBOUNCE_W-1:0] cnt;
  logic [NUM_BTN-1:0]                                press;
  rtc_setter_pkg::edit_op_e                          next_op;

  assign btn_raw = {btn_left_i, btn_right_i, btn_down_i, btn_up_i};

  // a press is clean on the sample that completes DEBOUNCE_CYCLES high samples
  always_comb
  begin
    for (int i = 0; i < NUM_BTN; i++)
    begin
      press[i] = btn_raw[i] && !level[i] &&
                 (cnt[i] == rtc_setter_pkg::DEBOUNCE_W'(rtc_setter_pkg::DEBOUNCE_CYCLES - 1));
    end
  end

  always_ff @(posedge clk or posedge Reset)
  begin
    if (Reset)
    begin
      level <= '0;
      cnt   <= '0;
    end
    else
    begin
      for (int i = 0; i < NUM_BTN; i++)
      begin
        if (btn_raw[i] != level[i])
        begin
          if (cnt[i] == rtc_setter_pkg::DEBOUNCE_W'(rtc_setter_pkg::DEBOUNCE_CYCLES - 1))
          begin
            level[i] <= btn_raw[i];  // held long enough, take the new level
            cnt[i]   <= '0;
          end
          else
          begin
            cnt[i] <= cnt[i] + 1'b1;
          end
        end
        else
        begin
          cnt[i] <= '0;  // bounce restarts the count
        end
      end
    end
  end

  always_comb
  begin
    if (press[0])
      next_op = rtc_setter_pkg::OP_INC;
    else if (press[1])
      next_op = rtc_setter_pkg::OP_DEC;
    else if (press[2])
      next_op = rtc_setter_pkg::OP_NEXT;
    else
      next_op = rtc_setter_pkg::OP_PREV;
  end

  // presses arriving while a command waits are dropped
  always_ff @(posedge clk or posedge Reset)
  begin
    if (Reset)
      cmd_valid_o <= 1'b0;
    else if (cmd_valid_o)
    begin
      if (cmd_ready_i)
        cmd_valid_o <= 1'b0;
    end
    else if (|press)
      cmd_valid_o <= 1'b1;
  end

  always_ff @(posedge clk)
  begin
    if (!cmd_valid_o && |press)
      cmd_op_o <= next_op;
  end

endmodule

/* common/rtc_write_if.sv */
`timescale 1ns/1ps

interface rtc_write_if ();

  logic                                  wr_valid;
  logic                                  wr_ready;
  logic [rtc_setter_pkg::REG_ADDR_W-1:0] wr_addr;
  logic [rtc_setter_pkg::REG_DATA_W-1:0] wr_data;
  logic                                  wr_release;  // marks the control release write

  modport seq (
    output wr_valid,
    output wr_addr,
    output wr_data,
    output wr_release,
    input  wr_ready
  );

  modport queue (
    input  wr_valid,
    input  wr_addr,
    input  wr_data,
    input  wr_release,
    output wr_ready
  );

endinterface

/* common/rtc_setter_pkg.sv */
package rtc_setter_pkg;

  // front panel commands
  typedef enum logic [1:0] {
    OP_INC,
    OP_DEC,
    OP_NEXT,
    OP_PREV
  } edit_op_e;

  // init states first, then the seven-field ring in register order
  typedef enum logic [3:0] {
    ST_INIT_HOLD,
    ST_INIT_RELEASE,
    ST_SECONDS,
    ST_MINUTES,
    ST_HOURS,
    ST_DAY,
    ST_MONTH,
    ST_YEAR,
    ST_WEEKDAY
  } seq_state_e;

  typedef struct packed {
    logic [7:0] seconds;
    logic [7:0] minutes;
    logic [7:0] hours;
    logic [7:0] day;
    logic [7:0] month;
    logic [7:0] year;
    logic [7:0] weekday;
  } rtc_time_t;

  localparam int REG_ADDR_W = 8;
  localparam int REG_DATA_W = 8;

  localparam logic [REG_ADDR_W-1:0] CTRL_ADDR       = 8'h02;
  localparam logic [REG_DATA_W-1:0] CTRL_HOLD       = 8'h10;
  localparam logic [REG_DATA_W-1:0] CTRL_RELEASE    = 8'h00;
  localparam logic [REG_ADDR_W-1:0] FIELD_ADDR_BASE = 8'h21;  // seconds, weekday at 0x27

  localparam int DEBOUNCE_CYCLES = 16;
  localparam int DEBOUNCE_W      = $clog2(DEBOUNCE_CYCLES);  // counts 0 .. DEBOUNCE_CYCLES-1

  localparam int QUEUE_DEPTH = 2;
  localparam int QUEUE_PTR_W = $clog2(QUEUE_DEPTH);
  localparam int QUEUE_CNT_W = $clog2(QUEUE_DEPTH + 1);

endpackage
